/* source/zx_mem_defs.svh */
//==============================
// Spectrum paging front end
// Fixed widths and constants of the memory map
//==============================
`ifndef ZX_MEM_DEFS_SVH
`define ZX_MEM_DEFS_SVH

//==============================
// Bus widths
//==============================
`define ZX_CPU_ADDR_W     16   // Z80 address bus
`define ZX_DATA_W         8    // Z80 data bus
`define ZX_RAM_ADDR_W     24   // SDRAM byte address
`define ZX_SDRAM_DATA_W   16   // One SDRAM word, two byte lanes

// Offset inside one 16K bank or ROM page
`define ZX_BANK_OFFSET_W  14

//==============================
// Memory map constants
//==============================
// ROM pages live above this prefix in SDRAM
`define ZX_ROM_REGION     3'b101

// Paging ports by their usual names
`define ZX_PORT_7FFD_TAG  16'h7FFD   // 128K bank register
`define ZX_PORT_1FFD_TAG  16'h1FFD   // +3 config register

`endif

/* source/zx_mem_pkg.sv */
//==============================
// Spectrum paging front end types
// Vector typedefs, model enum and stage structs
//==============================
`include "zx_mem_defs.svh"

package zx_mem_pkg;

	//==============================
	// Plain vectors
	//==============================
	typedef logic [`ZX_CPU_ADDR_W-1:0]   cpu_addr_t;
	typedef logic [`ZX_DATA_W-1:0]       byte_t;
	typedef logic [`ZX_RAM_ADDR_W-1:0]   ram_addr_t;
	typedef logic [`ZX_SDRAM_DATA_W-1:0] sdram_word_t;
	typedef logic [2:0]                  bank_t;      // 16K RAM bank
	typedef logic [3:0]                  rom_page_t;  // 16K ROM page

	// Machine type, latched at reset
	typedef enum logic [1:0] {
		MODEL_128K  = 2'd0,
		MODEL_48K   = 2'd1,
		MODEL_PLUS3 = 2'd2
	} mem_model_t;

	//==============================
	// Stage payloads
	//==============================
	// CPU pins, flags already active high
	typedef struct packed {
		cpu_addr_t addr;
		byte_t     data;   // CPU output byte
		logic      mreq;
		logic      iorq;
		logic      rd;
		logic      wr;
		logic      m1;
	} cpu_bus_t;

	typedef struct packed {
		cpu_addr_t addr;
		byte_t     data;
		logic      port_wr;  // One-cycle strobes
		logic      mem_rd;
		logic      mem_wr;
	} bus_event_t;

	typedef struct packed {
		mem_model_t model;
		byte_t      page_reg;        // Last 0x7FFD value
		byte_t      page_reg_plus3;  // Last 0x1FFD value
	} paging_state_t;

	typedef struct packed {
		logic      valid;
		logic      we;
		ram_addr_t ram_addr;
		byte_t     data;
	} mem_request_t;

	// Toggle handshake port of the SDRAM controller
	typedef struct packed {
		logic                      req;
		logic [`ZX_RAM_ADDR_W-2:0] addr;  // Word address
		logic [1:0]                ds;    // Upper, lower lane
		sdram_word_t               d;
		logic                      we;
	} sdram_cmd_t;

endpackage

/* source/cpu_cycle_decode.sv */
//==============================
// CPU cycle decode
// Registers the Z80 bus, makes one-cycle strobes
//==============================
module cpu_cycle_decode
	import zx_mem_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  cpu_bus_t   bus,
	output bus_event_t evt
);

	cpu_bus_t bus_q;       // Bus as seen last edge
	logic     io_wr;
	logic     mem_rd;
	logic     mem_wr;
	logic     io_wr_old;
	logic     mem_rd_old;
	logic     mem_wr_old;

	//==============================
	// Cycle conditions
	//==============================
	// M1 with IORQ is an interrupt acknowledge, not a port write
	assign io_wr  = bus_q.iorq & bus_q.wr & ~bus_q.m1;
	assign mem_rd = bus_q.mreq & bus_q.rd;
	assign mem_wr = bus_q.mreq & bus_q.wr;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bus_q      <= '0;
			io_wr_old  <= 1'b0;
			mem_rd_old <= 1'b0;
			mem_wr_old <= 1'b0;
			evt        <= '0;
		end else begin
			bus_q <= bus;

			// Previous-cycle copies for edge detection
			io_wr_old  <= io_wr;
			mem_rd_old <= mem_rd;
			mem_wr_old <= mem_wr;

			evt.addr    <= bus_q.addr;
			evt.data    <= bus_q.data;
			evt.port_wr <= io_wr & ~io_wr_old;    // Rising edges only
			evt.mem_rd  <= mem_rd & ~mem_rd_old;
			evt.mem_wr  <= mem_wr & ~mem_wr_old;
		end
	end

endmodule

/* source/paging_registers.sv */
//==============================
// Paging registers
// Model latch, 0x7FFD and 0x1FFD registers
//==============================
module paging_registers
	import zx_mem_pkg::*;
(
	input  logic          clk_sys,
	input  logic          reset,
	input  mem_model_t    mem_model,
	input  bus_event_t    evt_in,
	output bus_event_t    evt_out,
	output paging_state_t paging
);

	logic is_48k;
	logic is_plus3;
	logic page_lock;
	logic sel_7ffd;
	logic sel_1ffd;

	assign is_48k   = (paging.model == MODEL_48K);
	assign is_plus3 = (paging.model == MODEL_PLUS3);

	// 48K lock, sticky until the next reset
	assign page_lock = is_48k | paging.page_reg[5];

	//==============================
	// Port decode
	//==============================
	// Partial decode as on the real board, A15 and A1 low
	// The +3 also needs A14 high to tell 0x7FFD from 0x1FFD
	assign sel_7ffd = ~evt_in.addr[15] & ~evt_in.addr[1] &
		(evt_in.addr[14] | ~is_plus3);

	// 0x1FFD exists on the +3 only
	assign sel_1ffd = is_plus3 & ~evt_in.addr[1] & evt_in.addr[12] &
		(evt_in.addr[15:13] == 3'b000);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			paging.model          <= mem_model;   // Held while reset is high
			paging.page_reg       <= '0;
			paging.page_reg_plus3 <= '0;
			evt_out               <= '0;
		end else begin
			evt_out <= evt_in;

			// New value is visible with the write's own event
			if (evt_in.port_wr && !page_lock) begin
				if (sel_7ffd) begin
					paging.page_reg <= evt_in.data;
				end else if (sel_1ffd) begin
					paging.page_reg_plus3 <= evt_in.data;
				end
			end
		end
	end

endmodule

/* source/address_translator.sv */
//==============================
// Address translator
// CPU address to SDRAM byte address, ROM protect
//==============================
`include "zx_mem_defs.svh"

module address_translator
	import zx_mem_pkg::*;
(
	input  logic          clk_sys,
	input  logic          reset,
	input  bus_event_t    evt,
	input  paging_state_t paging,
	output mem_request_t  req
);

	logic [1:0]                   seg;      // 16K segment of the CPU map
	logic [1:0]                   cfg;      // +3 special config
	logic                         special;
	logic [`ZX_BANK_OFFSET_W-1:0] offset;
	rom_page_t                    rom_page;
	bank_t                        bank;
	ram_addr_t                    ram_addr;
	logic                         wr_allowed;

	assign seg     = evt.addr[15:14];
	assign offset  = evt.addr[`ZX_BANK_OFFSET_W-1:0];
	assign special = paging.page_reg_plus3[0];
	assign cfg     = paging.page_reg_plus3[2:1];

	always_comb begin
		case (paging.model)
			MODEL_48K:   rom_page = 4'b1111;
			MODEL_PLUS3: rom_page = {2'b10, paging.page_reg_plus3[2], paging.page_reg[4]};
			default:     rom_page = {3'b011, paging.page_reg[4]};
		endcase
	end

	//==============================
	// Bank select
	//==============================
	always_comb begin
		if (special) begin
			// All-RAM configs 0123, 4567, 4563, 4763
			case (seg)
				2'd0:    bank = {|cfg, 2'b00};
				2'd1:    bank = {|cfg, &cfg, 1'b1};
				2'd2:    bank = {|cfg, 2'b10};
				default: bank = {~cfg[1] & cfg[0], 2'b11};
			endcase
		end else begin
			case (seg)
				2'd1:    bank = 3'd5;
				2'd2:    bank = 3'd2;
				default: bank = paging.page_reg[2:0];  // Segment 0 is ROM, bank unused
			endcase
		end

		if (!special && seg == 2'd0) begin
			ram_addr = {3'b000, `ZX_ROM_REGION, rom_page, offset};
		end else begin
			ram_addr = {7'd0, bank, offset};
		end
	end

	// ROM is read only outside the special modes
	assign wr_allowed = special | (seg != 2'd0);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			req <= '0;
		end else begin
			req.valid    <= evt.mem_rd | (evt.mem_wr & wr_allowed);
			req.we       <= evt.mem_wr;
			req.ram_addr <= ram_addr;
			req.data     <= evt.data;
		end
	end

endmodule

/* source/sdram_requester.sv */
//==============================
// SDRAM requester
// Toggle handshake, byte lanes, read byte return
//==============================
`include "zx_mem_defs.svh"

module sdram_requester
	import zx_mem_pkg::*;
(
	input  logic         clk_sys,
	input  logic         reset,
	input  mem_request_t req,
	output sdram_cmd_t   sdram_cmd,
	input  logic         sdram_ack,
	input  sdram_word_t  sdram_q,
	output byte_t        ram_dout,
	output logic         ram_ready
);

	logic byte_sel;   // Address bit 0 of the current request

	//==============================
	// Request issue
	//==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sdram_cmd.req  <= sdram_ack;   // Nothing pending after reset
			sdram_cmd.we   <= 1'b0;
			sdram_cmd.addr <= '0;
			sdram_cmd.ds   <= 2'b11;
			sdram_cmd.d    <= '0;
			byte_sel       <= 1'b0;
		end else if (req.valid) begin
			sdram_cmd.req  <= ~sdram_cmd.req;   // Toggle starts a new access
			sdram_cmd.we   <= req.we;
			sdram_cmd.addr <= req.ram_addr[`ZX_RAM_ADDR_W-1:1];
			sdram_cmd.d    <= {req.data, req.data};
			byte_sel       <= req.ram_addr[0];

			// Odd byte on the upper lane, reads take the whole word
			if (req.we) begin
				sdram_cmd.ds <= {req.ram_addr[0], ~req.ram_addr[0]};
			end else begin
				sdram_cmd.ds <= 2'b11;
			end
		end
	end

	// Controller has caught up once ack matches req
	assign ram_ready = (sdram_ack == sdram_cmd.req);

	assign ram_dout = byte_sel ? sdram_q[15:8] : sdram_q[7:0];

endmodule

/* source/zx_memory_mapper.sv */
//==============================
// Spectrum memory mapper top
// Four-stage path from Z80 bus to SDRAM port
//==============================
module zx_memory_mapper
	import zx_mem_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  mem_model_t  mem_model,
	input  cpu_bus_t    cpu_bus,
	output sdram_cmd_t  sdram_cmd,
	input  logic        sdram_ack,
	input  sdram_word_t sdram_q,
	output byte_t       ram_dout,
	output logic        ram_ready
);

	bus_event_t    evt_decoded;   // Stage 1 out
	bus_event_t    evt_paged;     // Stage 2 out
	paging_state_t paging;
	mem_request_t  mem_req;       // Stage 3 out

	cpu_cycle_decode cpu_cycle_decode_inst (
		.clk_sys (clk_sys),
		.reset   (reset),
		.bus     (cpu_bus),
		.evt     (evt_decoded)
	);

	paging_registers paging_registers_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.mem_model (mem_model),
		.evt_in    (evt_decoded),
		.evt_out   (evt_paged),
		.paging    (paging)
	);

	address_translator address_translator_inst (
		.clk_sys (clk_sys),
		.reset   (reset),
		.evt     (evt_paged),
		.paging  (paging),
		.req     (mem_req)
	);

	sdram_requester sdram_requester_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.req       (mem_req),
		.sdram_cmd (sdram_cmd),
		.sdram_ack (sdram_ack),
		.sdram_q   (sdram_q),
		.ram_dout  (ram_dout),
		.ram_ready (ram_ready)
	);

endmodule

/* tb/sdram_responder.sv */
//==============================
// Model SDRAM controller port
// Answers each toggle after a set delay
//==============================
`include "zx_mem_defs.svh"

module sdram_responder
	import zx_mem_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  sdram_cmd_t  sdram_cmd,
	input  logic [2:0]  resp_delay,   // Cycles until ack, 1 to 6
	output logic        sdram_ack,
	output sdram_word_t sdram_q
);

	logic [`ZX_RAM_ADDR_W-2:0] word_addr[$];   // Written words only
	sdram_word_t               word_data[$];
	logic                      busy;
	logic [2:0]                wait_cnt;

	// Unwritten words read back as their own word address
	function automatic sdram_word_t fetch(input logic [`ZX_RAM_ADDR_W-2:0] addr);
		for (int i = 0; i < word_addr.size(); i++) begin
			if (word_addr[i] == addr) begin
				return word_data[i];
			end
		end
		return addr[15:0];
	endfunction

	task automatic store(input logic [`ZX_RAM_ADDR_W-2:0] addr, input logic [1:0] ds,
		input sdram_word_t d);
		sdram_word_t word;
		word = fetch(addr);
		if (ds[1]) word[15:8] = d[15:8];   // Upper lane
		if (ds[0]) word[7:0] = d[7:0];
		for (int i = 0; i < word_addr.size(); i++) begin
			if (word_addr[i] == addr) begin
				word_data[i] = word;
				return;
			end
		end
		word_addr.push_back(addr);
		word_data.push_back(word);
	endtask

	always @(posedge clk_sys) begin
		if (reset) begin
			sdram_ack <= 1'b0;
			busy      <= 1'b0;
			wait_cnt  <= '0;
			sdram_q   <= '0;
		end else if (!busy) begin
			if (sdram_cmd.req != sdram_ack) begin
				busy     <= 1'b1;   // New toggle seen
				wait_cnt <= resp_delay;
			end
		end else if (wait_cnt > 3'd1) begin
			wait_cnt <= wait_cnt - 3'd1;
		end else begin
			if (sdram_cmd.we) begin
				store(sdram_cmd.addr, sdram_cmd.ds, sdram_cmd.d);
			end else begin
				sdram_q <= fetch(sdram_cmd.addr);
			end
			sdram_ack <= sdram_cmd.req;   // One ack change per toggle
			busy      <= 1'b0;
		end
	end

endmodule

/* tb/zx_memory_mapper_properties.sv */
//==============================
// SDRAM handshake checks
//==============================
module zx_memory_mapper_properties
	import zx_mem_pkg::*;
(
	input logic         clk_sys,
	input logic         reset,
	input mem_request_t req,
	input sdram_cmd_t   sdram_cmd,
	input logic         sdram_ack,
	input logic         ram_ready
);

	int fail_count = 0;   // Failed assertions so far

	// CPU side waits for ram_ready before the next access
	assert property (@(posedge clk_sys) disable iff (reset)
		req.valid |-> ram_ready)
		else begin
			$error("new request while the previous one is open");
			fail_count++;
		end

	// Longest responder delay plus the cycle to see the toggle
	assert property (@(posedge clk_sys) disable iff (reset)
		$fell(ram_ready) |-> ##[1:8] ram_ready)
		else begin
			$error("SDRAM access not acknowledged in time");
			fail_count++;
		end

	// Each ack change answers the open toggle
	assert property (@(posedge clk_sys) disable iff (reset)
		!$stable(sdram_ack) |-> sdram_ack == sdram_cmd.req)
		else begin
			$error("ack changed to a value other than req");
			fail_count++;
		end

	assert property (@(posedge clk_sys) disable iff (reset)
		!$stable(sdram_ack) |-> $past(!ram_ready))
		else begin
			$error("ack changed with no access pending");
			fail_count++;
		end

endmodule

bind sdram_requester zx_memory_mapper_properties properties_inst (
	.clk_sys   (clk_sys),
	.reset     (reset),
	.req       (req),
	.sdram_cmd (sdram_cmd),
	.sdram_ack (sdram_ack),
	.ram_ready (ram_ready)
);

/* tb/tb_zx_memory_mapper.sv */
//==============================
// Memory mapper testbench
// Table-driven bus cycles against a model SDRAM
//==============================
`include "zx_mem_defs.svh"

module tb_zx_memory_mapper
	import zx_mem_pkg::*;
();

	localparam logic [1:0] OP_PORT   = 2'd0;
	localparam logic [1:0] OP_WRITE  = 2'd1;
	localparam logic [1:0] OP_READ   = 2'd2;
	localparam logic [1:0] OP_RESET  = 2'd3;
	localparam logic [1:0] EXP_NONE  = 2'd0;   // No byte to check
	localparam logic [1:0] EXP_LAST  = 2'd1;   // Byte of the last write
	localparam logic [1:0] EXP_PAT   = 2'd2;   // Unwritten, half of own word address
	localparam ram_addr_t  NO_ACCESS = 24'hFFFFFF;
	localparam int         CYCLE     = 40;

	typedef struct packed {
		mem_model_t model;
		logic [1:0] op;
		cpu_addr_t  addr;
		byte_t      data;       // Port writes only, memory data is random
		ram_addr_t  exp_addr;
		logic [1:0] exp_ds;
		logic [1:0] exp_kind;
	} test_entry_t;

	logic        clk_sys;
	logic        reset;
	mem_model_t  mem_model;
	cpu_bus_t    cpu_bus;
	sdram_cmd_t  sdram_cmd;
	logic        sdram_ack;
	sdram_word_t sdram_q;
	byte_t       ram_dout;
	logic        ram_ready;
	logic [2:0]  resp_delay;
	test_entry_t tests[$];
	int          test_count;
	int          errors;
	logic [31:0] rng_state;
	byte_t       last_byte;

	zx_memory_mapper zx_memory_mapper_inst (.*);
	sdram_responder sdram_responder_inst (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CYCLE / 2) clk_sys = ~clk_sys;
	end

	//==============================
	// Helpers
	//==============================
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic byte_t pattern_byte(input ram_addr_t a);
		return a[0] ? a[16:9] : a[8:1];   // Odd byte is the upper half
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s is %0h, expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic add_test(input mem_model_t model, input logic [1:0] op, input cpu_addr_t addr,
		input byte_t data, input ram_addr_t exp_addr, input logic [1:0] exp_ds,
		input logic [1:0] exp_kind);
		test_entry_t t;
		t = '{model, op, addr, data, exp_addr, exp_ds, exp_kind};
		tests.push_back(t);
	endtask

	task automatic apply_reset(input mem_model_t model);
		@(posedge clk_sys);
		reset     <= 1'b1;
		mem_model <= model;
		cpu_bus   <= '0;
		repeat (10) @(posedge clk_sys);
		reset <= 1'b0;
	endtask

	// One bus cycle, sampled by the DUT on the second edge
	task automatic drive_cycle(input cpu_bus_t value);
		@(posedge clk_sys);
		cpu_bus <= value;
		@(posedge clk_sys);
		cpu_bus <= '0;
	endtask

	task automatic run_access(input int idx, input test_entry_t t);
		cpu_bus_t cycle;
		logic     req_before;
		byte_t    data;
		int       delay;
		int       cycles;
		rng_state = xorshift(rng_state);
		data = rng_state[7:0];
		delay = rng_state[15:8] % 6 + 1;
		cycle = '{t.addr, data, 1'b1, 1'b0, t.op == OP_READ, t.op == OP_WRITE, 1'b0};
		req_before = sdram_cmd.req;
		drive_cycle(cycle);
		resp_delay <= delay[2:0];
		cycles = 0;
		while (sdram_cmd.req === req_before && cycles < 8) begin
			@(posedge clk_sys);
			cycles++;
			@(negedge clk_sys);
		end
		if (t.exp_addr == NO_ACCESS) begin
			check("req after protected write", sdram_cmd.req, req_before);
			check("ram_ready", ram_ready, 1'b1);
		end else if (sdram_cmd.req === req_before) begin
			$display("Test %0d: no SDRAM request within 8 cycles", idx);
			errors++;
		end else begin
			check("request latency", cycles, 4);
			check("word address", sdram_cmd.addr, t.exp_addr[23:1]);
			check("ds", sdram_cmd.ds, t.exp_ds);
			check("we", sdram_cmd.we, t.op == OP_WRITE);
			check("ram_ready while pending", ram_ready, 1'b0);
			if (t.op == OP_WRITE) begin
				check("write data", sdram_cmd.d, {data, data});
				last_byte = data;
			end
			cycles = 0;
			while (!ram_ready && cycles < 16) begin
				@(negedge clk_sys);
				cycles++;
			end
			if (!ram_ready) begin
				$display("Test %0d: SDRAM access never completed", idx);
				errors++;
			end else if (t.exp_kind != EXP_NONE) begin
				check("ram_dout", ram_dout,
					(t.exp_kind == EXP_LAST) ? last_byte : pattern_byte(t.exp_addr));
			end
		end
	endtask

	//==============================
	// Stimulus table
	//==============================
	task automatic build_table();
		add_test(MODEL_128K, OP_READ, 16'hC010, 8'h00, 24'h000010, 2'b11, EXP_PAT);
		add_test(MODEL_128K, OP_PORT, `ZX_PORT_7FFD_TAG, 8'h03, NO_ACCESS, 2'b00, EXP_NONE);
		add_test(MODEL_128K, OP_WRITE, 16'hC011, 8'h00, 24'h00C011, 2'b10, EXP_NONE);
		add_test(MODEL_128K, OP_READ, 16'hC011, 8'h00, 24'h00C011, 2'b11, EXP_LAST);
		add_test(MODEL_128K, OP_READ, 16'h4020, 8'h00, 24'h014020, 2'b11, EXP_PAT);
		add_test(MODEL_128K, OP_READ, 16'h8021, 8'h00, 24'h008021, 2'b11, EXP_PAT);
		add_test(MODEL_128K, OP_PORT, `ZX_PORT_7FFD_TAG, 8'h17, NO_ACCESS, 2'b00, EXP_NONE);
		add_test(MODEL_128K, OP_READ, 16'h0100, 8'h00, 24'h15C100, 2'b11, EXP_PAT);
		add_test(MODEL_128K, OP_WRITE, 16'h0200, 8'h00, NO_ACCESS, 2'b00, EXP_NONE);
		add_test(MODEL_128K, OP_PORT, `ZX_PORT_7FFD_TAG, 8'h21, NO_ACCESS, 2'b00, EXP_NONE);
		add_test(MODEL_128K, OP_PORT, `ZX_PORT_7FFD_TAG, 8'h16, NO_ACCESS, 2'b00, EXP_NONE);
		add_test(MODEL_128K, OP_READ, 16'hC030, 8'h00, 24'h004030, 2'b11, EXP_PAT);
		add_test(MODEL_128K, OP_READ, 16'h0300, 8'h00, 24'h158300, 2'b11, EXP_PAT);
		add_test(MODEL_128K, OP_RESET, 16'h0000, 8'h00, NO_ACCESS, 2'b00, EXP_NONE);
		add_test(MODEL_128K, OP_READ, 16'hC031, 8'h00, 24'h000031, 2'b11, EXP_PAT);
		add_test(MODEL_48K, OP_PORT, `ZX_PORT_7FFD_TAG, 8'h03, NO_ACCESS, 2'b00, EXP_NONE);
		add_test(MODEL_48K, OP_READ, 16'hC040, 8'h00, 24'h000040, 2'b11, EXP_PAT);
		add_test(MODEL_48K, OP_READ, 16'h0040, 8'h00, 24'h17C040, 2'b11, EXP_PAT);
		add_test(MODEL_PLUS3, OP_PORT, `ZX_PORT_1FFD_TAG, 8'h01, NO_ACCESS, 2'b00, EXP_NONE);
		add_test(MODEL_PLUS3, OP_READ, 16'h0050, 8'h00, 24'h000050, 2'b11, EXP_PAT);
		add_test(MODEL_PLUS3, OP_READ, 16'h4051, 8'h00, 24'h004051, 2'b11, EXP_PAT);
		add_test(MODEL_PLUS3, OP_READ, 16'h8052, 8'h00, 24'h008052, 2'b11, EXP_PAT);
		add_test(MODEL_PLUS3, OP_READ, 16'hC053, 8'h00, 24'h00C053, 2'b11, EXP_PAT);
		add_test(MODEL_PLUS3, OP_PORT, `ZX_PORT_1FFD_TAG, 8'h03, NO_ACCESS, 2'b00, EXP_NONE);
		add_test(MODEL_PLUS3, OP_READ, 16'h0054, 8'h00, 24'h010054, 2'b11, EXP_PAT);
		add_test(MODEL_PLUS3, OP_READ, 16'h4055, 8'h00, 24'h014055, 2'b11, EXP_PAT);
		add_test(MODEL_PLUS3, OP_READ, 16'h8056, 8'h00, 24'h018056, 2'b11, EXP_PAT);
		add_test(MODEL_PLUS3, OP_READ, 16'hC057, 8'h00, 24'h01C057, 2'b11, EXP_PAT);
		add_test(MODEL_PLUS3, OP_PORT, `ZX_PORT_1FFD_TAG, 8'h05, NO_ACCESS, 2'b00, EXP_NONE);
		add_test(MODEL_PLUS3, OP_READ, 16'h0058, 8'h00, 24'h010058, 2'b11, EXP_PAT);
		add_test(MODEL_PLUS3, OP_READ, 16'h4059, 8'h00, 24'h014059, 2'b11, EXP_PAT);
		add_test(MODEL_PLUS3, OP_READ, 16'h805A, 8'h00, 24'h01805A, 2'b11, EXP_PAT);
		add_test(MODEL_PLUS3, OP_READ, 16'hC05B, 8'h00, 24'h00C05B, 2'b11, EXP_PAT);
		add_test(MODEL_PLUS3, OP_PORT, `ZX_PORT_1FFD_TAG, 8'h07, NO_ACCESS, 2'b00, EXP_NONE);
		add_test(MODEL_PLUS3, OP_READ, 16'h005C, 8'h00, 24'h01005C, 2'b11, EXP_PAT);
		add_test(MODEL_PLUS3, OP_READ, 16'h405D, 8'h00, 24'h01C05D, 2'b11, EXP_PAT);
		add_test(MODEL_PLUS3, OP_READ, 16'h805E, 8'h00, 24'h01805E, 2'b11, EXP_PAT);
		add_test(MODEL_PLUS3, OP_READ, 16'hC05F, 8'h00, 24'h00C05F, 2'b11, EXP_PAT);
		add_test(MODEL_PLUS3, OP_WRITE, 16'h0060, 8'h00, 24'h010060, 2'b01, EXP_NONE);
		add_test(MODEL_PLUS3, OP_READ, 16'h0060, 8'h00, 24'h010060, 2'b11, EXP_LAST);
		add_test(MODEL_PLUS3, OP_PORT, `ZX_PORT_1FFD_TAG, 8'h04, NO_ACCESS, 2'b00, EXP_NONE);
		add_test(MODEL_PLUS3, OP_READ, 16'h0070, 8'h00, 24'h168070, 2'b11, EXP_PAT);
	endtask

	//==============================
	// Main sequence and watchdog
	//==============================
	initial begin
		int         errors_before;
		int         passed;
		int         failed;
		int         assert_fails;
		mem_model_t cur_model;
		reset      = 1'b1;
		mem_model  = MODEL_128K;
		cpu_bus    = '0;
		resp_delay = 3'd1;
		rng_state  = 32'h67b0ca3f;
		errors     = 0;
		passed     = 0;
		failed     = 0;
		build_table();
		test_count = tests.size();
		cur_model  = MODEL_128K;
		apply_reset(cur_model);
		for (int i = 0; i < test_count; i++) begin
			errors_before = errors;
			if (tests[i].op == OP_RESET || tests[i].model != cur_model) begin
				cur_model = tests[i].model;   // Model only changes through reset
				apply_reset(cur_model);
			end
			if (tests[i].op == OP_PORT) begin
				drive_cycle('{tests[i].addr, tests[i].data, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0});
				repeat (3) @(posedge clk_sys);
			end else if (tests[i].op != OP_RESET) begin
				run_access(i, tests[i]);
			end
			if (errors == errors_before) begin
				passed++;
				$display("Test %0d op %0d addr %h: ok", i, tests[i].op, tests[i].addr);
			end else begin
				failed++;
				$display("Test %0d op %0d addr %h: FAILED", i, tests[i].op, tests[i].addr);
			end
		end
		assert_fails = zx_memory_mapper_inst.sdram_requester_inst.properties_inst.fail_count;
		$display("Summary: %0d tests, %0d ok, %0d failed, %0d assertion failures",
			test_count, passed, failed, assert_fails);
		if (failed == 0 && assert_fails == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		wait (test_count > 0);
		#(test_count * 40 * CYCLE);
		$display("Watchdog timeout, the tests did not finish in time");
		$display("Simulation failed");
		$finish;
	end

endmodule

/* compile.f */
+incdir+source
source/zx_mem_pkg.sv
source/cpu_cycle_decode.sv
source/paging_registers.sv
source/address_translator.sv
source/sdram_requester.sv
source/zx_memory_mapper.sv
tb/sdram_responder.sv
tb/zx_memory_mapper_properties.sv
tb/tb_zx_memory_mapper.sv

/* Bender.yml */
package:
  name: zx_memory_mapper

sources:
  - include_dirs:
      - source
    files:
      - source/zx_mem_pkg.sv
      - source/cpu_cycle_decode.sv
      - source/paging_registers.sv
      - source/address_translator.sv
      - source/sdram_requester.sv
      - source/zx_memory_mapper.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - tb/sdram_responder.sv
      - tb/zx_memory_mapper_properties.sv
      - tb/tb_zx_memory_mapper.sv
